// ==== Bender.yml ====
package:
  name: skenc

sources:
  # RTL
  - files:
      - logic/skenc_pkg.sv
      - logic/wb_host_regs.sv
      - logic/coeff_mem.sv
      - logic/sk_fetch.sv
      - logic/sk_coeff_map.sv
      - logic/sk_pack.sv
      - logic/key_mem.sv
      - logic/skenc_top.sv

  # Testbench
  - target: simulation
    files:
      - bench/skenc_tb.sv

// ==== bench/skenc_golden.txt ====
# C <row> <lane 0..7 coefficients, hex> | K <word> <expected key word, hex>
# E <row> <lane> <invalid coefficient, hex>   (K=2 L=2 N=32, eta=2)
C 0 000000 000000 000000 000000 000000 000000 000000 000000
C 1 000002 000001 000000 7fe000 7fdfff 000002 000001 000000
C 2 7fe000 7fdfff 000002 000001 000000 7fe000 7fdfff 000002
C 3 000001 000001 000001 000001 000001 000001 000001 000001
C 4 7fe000 7fe000 7fe000 7fe000 7fe000 7fe000 7fe000 7fe000
C 5 7fdfff 7fdfff 7fdfff 7fdfff 7fdfff 7fdfff 7fdfff 7fdfff
C 6 000002 000002 000002 000002 000002 000002 000002 000002
C 7 7fdfff 7fe000 000000 000001 000002 7fdfff 7fe000 000000
C 8 000002 7fdfff 000002 7fdfff 000002 7fdfff 000002 7fdfff
C 9 7fe000 000000 7fe000 000000 7fe000 000000 7fe000 000000
C 10 000001 000002 000001 000002 000001 000002 000001 000002
C 11 000000 000000 000000 000000 7fe000 7fe000 7fe000 7fe000
C 12 7fdfff 7fdfff 7fdfff 7fdfff 000001 000001 000001 000001
C 13 000002 000001 000000 7fe000 7fdfff 7fdfff 7fe000 000000
C 14 000000 000002 000000 000002 000000 000002 000000 000002
C 15 7fe000 7fdfff 7fe000 7fdfff 7fe000 7fdfff 7fe000 7fdfff
K 0 88492492
K 1 a2234446
K 2 24924911
K 3 246db6db
K 4 00009249
K 5 4e029c00
K 6 d3820820
K 7 10414d34
K 8 6db49204
K 9 88249924
K 10 20824e46
K 11 8e38e308
E 5 3 7fe001

// ==== bench/skenc_tb.sv ====
// Testbench for the s1/s2 encoder, built with K=2, L=2 and N=32.
// Coefficients and expected key words come from bench/skenc_golden.txt, so
// the simulator must be started in the project root.
`timescale 1ns/1ps
`default_nettype none

module skenc_tb
    import skenc_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int TB_K       = 2;
    localparam int TB_L       = 2;
    localparam int TB_N       = 32;
    localparam int RUN_COEFFS = (TB_K + TB_L) * TB_N;
    localparam int RUN_ROWS   = RUN_COEFFS / 8;
    localparam int RUN_WORDS  = RUN_COEFFS * 3 / 32;
    localparam int AREA2_DEST = 20;
    localparam int RERUN_DEST = 8;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 100;
    localparam logic [31:0] SEED = 32'h149a_6a4d;

    // Five runs of about 40 cycles plus roughly 420 bus accesses of up to
    // 4 cycles each, with a margin of six.
    localparam int RUN_CYCLES    = 40;
    localparam int N_RUNS        = 5;
    localparam int N_ACCESSES    = 420;
    localparam int ACCESS_CYCLES = 4;
    localparam int WATCHDOG_NS   =
        6 * CLK_PERIOD * (N_RUNS * RUN_CYCLES + N_ACCESSES * ACCESS_CYCLES);

    logic               clk;
    logic               reset_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [WB_AW-1:0]   wb_adr;
    logic [WB_DW-1:0]   wb_dat_w;
    logic [WB_DW/8-1:0] wb_sel;
    logic [WB_DW-1:0]   wb_dat_r;
    logic               wb_ack;
    logic               irq;

    logic [COEFF_W-1:0] golden_coeff [RUN_COEFFS];
    logic [WB_DW-1:0]   golden_key [RUN_WORDS];
    int                 err_row;
    int                 err_lane;
    logic [COEFF_W-1:0] err_val;
    int                 error_count = 0;
    int                 irq_count = 0;

    skenc_top #(
        .MLDSA_K(TB_K), .MLDSA_L(TB_L), .MLDSA_N(TB_N)
    ) skenc_top_i (
        .clk, .reset_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
        .irq
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Each run ends with a one-cycle interrupt, whether done or error.
    always @(posedge clk) begin
        if (irq) begin
            irq_count <= irq_count + 1;
        end
    end

    // ========================================================================
    // Failure reporting and checks
    // ========================================================================
    task automatic end_in_failure;
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_with(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        end_in_failure();
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            end_in_failure();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_with($sformatf("watchdog expired after %0d ns, the tests did not finish",
                            WATCHDOG_NS));
    end

    // ========================================================================
    // Wishbone master
    // ========================================================================
    task automatic wait_ack;
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_LIMIT) begin
                fail_with("the slave never acknowledged a bus access");
            end
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] data);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wb_sel   = '1;
        wait_ack();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] addr, output logic [WB_DW-1:0] data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wb_sel = '1;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Word slot of coefficient index within the area starting at base_row.
    function automatic logic [WB_AW-1:0] coeff_addr(input int base_row, input int index);
        return COEFF_WIN + WB_AW'(4 * (base_row * 8 + index));
    endfunction

    // Polls until done or error is set and returns the final status.
    task automatic wait_run_end(output logic [WB_DW-1:0] status);
        int polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_with("the encoder never reported the end of a run");
            end
        end while (status[2:1] == 2'b00);
    endtask

    task automatic start_run(input int src, input int dest);
        wb_write(REG_SRC_ROW, WB_DW'(src));
        wb_write(REG_DEST_ADDR, WB_DW'(dest));
        wb_write(REG_CTRL, 32'h1);
    endtask

    task automatic load_vector(input int base_row);
        for (int i = 0; i < RUN_COEFFS; i++) begin
            wb_write(coeff_addr(base_row, i), WB_DW'(golden_coeff[i]));
        end
    endtask

    task automatic check_words(input int dest);
        logic [WB_DW-1:0] data;
        for (int w = 0; w < RUN_WORDS; w++) begin
            wb_read(KEY_WIN + WB_AW'(4 * (dest + w)), data);
            check_eq($sformatf("key word %0d", dest + w), data, golden_key[w]);
        end
    endtask

    // ========================================================================
    // Golden file
    // ========================================================================
    task automatic load_golden;
        int                fd;
        int                rc;
        int                index;
        int                n_rows;
        int                n_words;
        int                n_errs;
        logic [63:0]       tag;
        logic [31:0]       value;
        logic [8*160-1:0]  rest;
        n_rows  = 0;
        n_words = 0;
        n_errs  = 0;
        fd = $fopen("bench/skenc_golden.txt", "r");
        if (fd == 0) begin
            fail_with("cannot open bench/skenc_golden.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                rc = $fgets(rest, fd);
            end else if (tag == "C") begin
                rc = $fscanf(fd, "%d", index);
                if (rc != 1 || index < 0 || index >= RUN_ROWS) begin
                    fail_with("bad row index on a C line of the golden file");
                end
                for (int lane = 0; lane < 8; lane++) begin
                    rc = $fscanf(fd, "%h", value);
                    golden_coeff[index * 8 + lane] = value[COEFF_W-1:0];
                end
                n_rows++;
            end else if (tag == "K") begin
                rc = $fscanf(fd, "%d %h", index, value);
                if (rc != 2 || index < 0 || index >= RUN_WORDS) begin
                    fail_with("bad word index on a K line of the golden file");
                end
                golden_key[index] = value;
                n_words++;
            end else if (tag == "E") begin
                rc = $fscanf(fd, "%d %d %h", err_row, err_lane, value);
                err_val = value[COEFF_W-1:0];
                n_errs++;
            end else begin
                fail_with("unknown line tag in the golden file");
            end
        end
        $fclose(fd);
        if (n_rows != RUN_ROWS || n_words != RUN_WORDS || n_errs != 1) begin
            fail_with("the golden file does not hold a complete test set");
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        logic [WB_DW-1:0] data;
        logic [WB_DW-1:0] status;
        logic [31:0]      seed_draw;
        int               irq_before;
        int               delay;

        reset_n  = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        seed_draw = $urandom(SEED);

        load_golden();
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        // Reset values and register readback.
        check_eq("wb_ack", 32'(wb_ack), 32'h0);
        check_eq("irq", 32'(irq), 32'h0);
        wb_read(REG_STATUS, data);
        check_eq("STATUS", data, 32'h0);
        wb_write(REG_SRC_ROW, 32'h13);
        wb_write(REG_DEST_ADDR, 32'h0b);
        wb_read(REG_SRC_ROW, data);
        check_eq("SRC_ROW", data, 32'h13);
        wb_read(REG_DEST_ADDR, data);
        check_eq("DEST_ADDR", data, 32'h0b);

        // Plain run from area 0 to key word 0.
        load_vector(0);
        start_run(0, 0);
        wait_run_end(status);
        check_eq("STATUS", status, 32'h2);
        check_words(0);

        // Same vector staged in the second area.
        load_vector(RUN_ROWS);
        start_run(RUN_ROWS, AREA2_DEST);
        wait_run_end(status);
        check_eq("STATUS", status, 32'h2);
        check_words(AREA2_DEST);

        // An invalid coefficient ends the run with the error bit.
        wb_write(coeff_addr(0, err_row * 8 + err_lane), WB_DW'(err_val));
        irq_before = irq_count;
        start_run(0, 0);
        wait_run_end(status);
        check_eq("STATUS", status, 32'h4);
        repeat (3) @(negedge clk);
        check_eq("irq pulses", 32'(irq_count - irq_before), 32'h1);

        // Restore, then abort a run. The coefficient write lands while busy.
        wb_write(coeff_addr(0, err_row * 8 + err_lane),
                 WB_DW'(golden_coeff[err_row * 8 + err_lane]));
        start_run(0, 0);
        delay = 1 + ($urandom % 10);
        repeat (delay) @(negedge clk);
        wb_write(coeff_addr(0, 9), 32'h007f_e000);
        wb_write(REG_CTRL, 32'h2);
        wb_read(REG_STATUS, data);
        check_eq("STATUS", data, 32'h0);

        start_run(0, RERUN_DEST);
        wait_run_end(status);
        check_eq("STATUS", status, 32'h2);
        check_words(RERUN_DEST);

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            end_in_failure();
        end
    end

endmodule

`default_nettype wire

// ==== logic/coeff_mem.sv ====
// Coefficient RAM banked by lane: one host write per cycle, one row read.
// Depth covers two run areas. Read data is registered.
`timescale 1ns/1ps
`default_nettype none

module coeff_mem
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int ROW_AW = row_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int LANE_W = $clog2(LANES),
    localparam int CW     = ROW_AW + LANE_W
) (
    input  wire                              clk,
    input  wire                              wr_en,
    input  wire [CW-1:0]                     wr_addr,
    input  wire [COEFF_W-1:0]                wr_data,
    input  wire                              rd_en,
    input  wire [ROW_AW-1:0]                 rd_row,
    output logic [LANES-1:0][COEFF_W-1:0]    row_data,
    output logic                             row_valid
);

    for (genvar lane = 0; lane < LANES; lane++) begin : g_bank
        logic [COEFF_W-1:0] bank [2**ROW_AW];

        always_ff @(posedge clk) begin
            if (wr_en && wr_addr[LANE_W-1:0] == LANE_W'(lane)) begin
                bank[wr_addr[CW-1:LANE_W]] <= wr_data;
            end
            if (rd_en) begin
                row_data[lane] <= bank[rd_row];
            end
        end
    end

    // Row data is valid one cycle after a read request.
    always_ff @(posedge clk) begin
        row_valid <= rd_en;
    end

endmodule

`default_nettype wire

// ==== logic/key_mem.sv ====
// Key RAM: one write port for the pack stage, registered host read port.
`timescale 1ns/1ps
`default_nettype none

module key_mem
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int KEY_AW = key_aw(MLDSA_K, MLDSA_L, MLDSA_N)
) (
    input  wire               clk,
    input  wire               wr_en,
    input  wire [KEY_AW-1:0]  wr_addr,
    input  wire [WB_DW-1:0]   wr_data,
    input  wire [KEY_AW-1:0]  rd_addr,
    output logic [WB_DW-1:0]  rd_data
);

    logic [WB_DW-1:0] mem [2**KEY_AW];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/sk_coeff_map.sv ====
// Map stage for eta = 2. Each lane becomes the 3-bit code eta minus the
// coefficient; lane 0 lands in the low bits of the string.
`timescale 1ns/1ps
`default_nettype none

module sk_coeff_map
    import skenc_pkg::*;
(
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize,
    input  wire                            row_valid,
    input  wire [LANES-1:0][COEFF_W-1:0]   row_data,
    output logic                           str_valid,
    output logic [STRING_W-1:0]            str_data,
    output logic                           err_pulse
);

    logic [LANES-1:0][CODE_W-1:0] codes;
    logic [LANES-1:0]             bad;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            bad[i] = 1'b0;
            case (row_data[i])
                COEFF_W'(0):           codes[i] = 3'd2;
                COEFF_W'(1):           codes[i] = 3'd1;
                COEFF_W'(2):           codes[i] = 3'd0;
                COEFF_W'(MLDSA_Q - 1): codes[i] = 3'd3;
                COEFF_W'(MLDSA_Q - 2): codes[i] = 3'd4;
                default: begin
                    codes[i] = 3'd0;
                    bad[i]   = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            str_valid <= 1'b0;
            err_pulse <= 1'b0;
        end else begin
            str_valid <= row_valid && !(|bad);
            err_pulse <= row_valid && (|bad);
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            str_data <= codes;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sk_fetch.sv ====
// Fetch stage. Walks the rows of one run from the latched source row,
// one row per cycle, then drains for two cycles before accepting a start.
`timescale 1ns/1ps
`default_nettype none

module sk_fetch
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int ROW_AW   = row_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int RUN_ROWS = run_rows(MLDSA_K, MLDSA_L, MLDSA_N)
) (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               start,
    input  wire               zeroize,
    input  wire [ROW_AW-1:0]  src_row,
    input  wire               err_pulse,
    output logic              rd_en,
    output logic [ROW_AW-1:0] rd_row
);

    fetch_state_e      state;
    logic [ROW_AW-1:0] count;
    logic [ROW_AW-1:0] base_row;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        count <= '0;
                    end
                end
                RUN: begin
                    // An invalid coefficient ends the walk early.
                    if (err_pulse || count == ROW_AW'(RUN_ROWS - 1)) begin
                        state <= DRAIN;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                DRAIN: begin
                    if (count == ROW_AW'(1)) begin
                        state <= IDLE;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    count <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            base_row <= src_row;
        end
    end

    assign rd_en  = (state == RUN);
    assign rd_row = base_row + count;

endmodule

`default_nettype wire

// ==== logic/sk_pack.sv ====
// Pack stage. Appends 24-bit code strings to an accumulator and writes
// 32-bit words at consecutive key addresses from the latched destination.
// The per-run bit total must be a multiple of 32 (N a multiple of 32).
`timescale 1ns/1ps
`default_nettype none

module sk_pack
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int KEY_AW    = key_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int RUN_WORDS = run_words(MLDSA_K, MLDSA_L, MLDSA_N)
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                start,
    input  wire                zeroize,
    input  wire [KEY_AW-1:0]   dest_addr,
    input  wire                str_valid,
    input  wire [STRING_W-1:0] str_data,
    input  wire                err_pulse,
    output logic               key_wr_en,
    output logic [KEY_AW-1:0]  key_wr_addr,
    output logic [WB_DW-1:0]   key_wr_data,
    output logic               run_done
);

    // At most 24 bits in and 32 bits out per cycle, so 56 bits never overflow.
    localparam int ACC_W = WB_DW + STRING_W;
    localparam int CNT_W = $clog2(ACC_W);

    logic [ACC_W-1:0]  acc;
    logic [ACC_W-1:0]  acc_base;
    logic [CNT_W-1:0]  bits;
    logic [CNT_W-1:0]  bits_base;
    logic [KEY_AW-1:0] word_cnt;
    logic [KEY_AW-1:0] base_addr;
    logic              active;
    logic              emit;
    logic              last;
    logic              wr_last;

    assign emit = active && (bits >= CNT_W'(WB_DW));
    assign last = (word_cnt == KEY_AW'(RUN_WORDS - 1));

    // Bits left after this cycle's word goes out.
    always_comb begin
        acc_base  = emit ? (acc >> WB_DW) : acc;
        bits_base = emit ? (bits - CNT_W'(WB_DW)) : bits;
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            active    <= 1'b0;
            bits      <= '0;
            word_cnt  <= '0;
            key_wr_en <= 1'b0;
            wr_last   <= 1'b0;
            run_done  <= 1'b0;
        end else begin
            key_wr_en <= emit;
            wr_last   <= emit && last;
            run_done  <= key_wr_en && wr_last;
            if (start) begin
                active   <= 1'b1;
                bits     <= '0;
                word_cnt <= '0;
            end else if (err_pulse || (emit && last)) begin
                // An error discards whatever is still held.
                active <= 1'b0;
                bits   <= '0;
            end else begin
                if (str_valid && active) begin
                    bits <= bits_base + CNT_W'(STRING_W);
                end else begin
                    bits <= bits_base;
                end
                if (emit) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Bits above the count stay zero, so a new string can be OR-ed in.
    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= '0;
            base_addr <= dest_addr;
        end else if (str_valid && active) begin
            acc <= acc_base | (ACC_W'(str_data) << bits_base);
        end else begin
            acc <= acc_base;
        end
        if (emit) begin
            key_wr_data <= acc[WB_DW-1:0];
            key_wr_addr <= base_addr + word_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/skenc_pkg.sv ====
// Shared constants, register map and types for the ML-DSA s1/s2 encoder.
// Only eta = 2 is supported. Memory sizing functions reserve two run areas
// so that a second vector can be staged behind the first.
`default_nettype none

package skenc_pkg;

    // ========================================================================
    // Arithmetic and datapath widths
    // ========================================================================
    localparam logic [22:0] MLDSA_Q  = 23'd8380417;
    localparam int          COEFF_W  = 24;
    localparam int          LANES    = 8;
    localparam int          CODE_W   = 3;
    localparam int          STRING_W = LANES * CODE_W;
    localparam int          WB_DW    = 32;
    localparam int          WB_AW    = 16;

    // Register byte offsets. CTRL bit 0 is start, bit 1 is zeroize.
    localparam logic [WB_AW-1:0] REG_CTRL      = 16'h0000;
    localparam logic [WB_AW-1:0] REG_STATUS    = 16'h0004;
    localparam logic [WB_AW-1:0] REG_SRC_ROW   = 16'h0008;
    localparam logic [WB_AW-1:0] REG_DEST_ADDR = 16'h000C;

    // Memory windows, one 32-bit slot per coefficient or key word.
    localparam logic [WB_AW-1:0] COEFF_WIN = 16'h1000;
    localparam logic [WB_AW-1:0] KEY_WIN   = 16'h2000;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } fetch_state_e;

    typedef enum logic [1:0] {
        REGION_REG,
        REGION_COEFF,
        REGION_KEY,
        REGION_NONE
    } wb_region_e;

    // Rows of eight coefficients in one run of s1 and s2.
    function automatic int run_rows(input int k, input int l, input int n);
        return (k + l) * n / LANES;
    endfunction

    // Packed 32-bit key words produced by one run.
    function automatic int run_words(input int k, input int l, input int n);
        return CODE_W * (k + l) * n / WB_DW;
    endfunction

    function automatic int row_aw(input int k, input int l, input int n);
        return $clog2(2 * run_rows(k, l, n));
    endfunction

    function automatic int key_aw(input int k, input int l, input int n);
        return $clog2(2 * run_words(k, l, n));
    endfunction

endpackage

`default_nettype wire

// ==== logic/skenc_top.sv ====
// ML-DSA s1/s2 secret-key encoder with a Wishbone classic host port.
// Pipeline: fetch, map, pack, key write. Eta = 2 only.
`timescale 1ns/1ps
`default_nettype none

module skenc_top
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int ROW_AW = row_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int KEY_AW = key_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int CW     = ROW_AW + $clog2(LANES)
) (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               wb_cyc,
    input  wire               wb_stb,
    input  wire               wb_we,
    input  wire [WB_AW-1:0]   wb_adr,
    input  wire [WB_DW-1:0]   wb_dat_w,
    input  wire [WB_DW/8-1:0] wb_sel,
    output logic [WB_DW-1:0]  wb_dat_r,
    output logic              wb_ack,
    output logic              irq
);

    // ========================================================================
    // Interconnect
    // ========================================================================
    logic                          start;
    logic                          zeroize;
    logic [ROW_AW-1:0]             src_row;
    logic [KEY_AW-1:0]             dest_addr;
    logic                          run_done;
    logic                          err_pulse;
    logic                          coeff_wr_en;
    logic [CW-1:0]                 coeff_wr_addr;
    logic [COEFF_W-1:0]            coeff_wr_data;
    logic [KEY_AW-1:0]             key_rd_addr;
    logic [WB_DW-1:0]              key_rd_data;
    logic                          rd_en;
    logic [ROW_AW-1:0]             rd_row;
    logic [LANES-1:0][COEFF_W-1:0] row_data;
    logic                          row_valid;
    logic                          str_valid;
    logic [STRING_W-1:0]           str_data;
    logic                          key_wr_en;
    logic [KEY_AW-1:0]             key_wr_addr;
    logic [WB_DW-1:0]              key_wr_data;

    wb_host_regs #(
        .MLDSA_K(MLDSA_K), .MLDSA_L(MLDSA_L), .MLDSA_N(MLDSA_N)
    ) wb_host_regs_i (
        .clk, .reset_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
        .start, .zeroize, .src_row, .dest_addr,
        .run_done, .err_pulse, .irq,
        .coeff_wr_en, .coeff_wr_addr, .coeff_wr_data,
        .key_rd_addr, .key_rd_data
    );

    coeff_mem #(
        .MLDSA_K(MLDSA_K), .MLDSA_L(MLDSA_L), .MLDSA_N(MLDSA_N)
    ) coeff_mem_i (
        .clk,
        .wr_en   (coeff_wr_en),
        .wr_addr (coeff_wr_addr),
        .wr_data (coeff_wr_data),
        .rd_en, .rd_row, .row_data, .row_valid
    );

    sk_fetch #(
        .MLDSA_K(MLDSA_K), .MLDSA_L(MLDSA_L), .MLDSA_N(MLDSA_N)
    ) sk_fetch_i (
        .clk, .reset_n, .start, .zeroize, .src_row, .err_pulse, .rd_en, .rd_row
    );

    sk_coeff_map sk_coeff_map_i (
        .clk, .reset_n, .zeroize, .row_valid, .row_data, .str_valid, .str_data, .err_pulse
    );

    sk_pack #(
        .MLDSA_K(MLDSA_K), .MLDSA_L(MLDSA_L), .MLDSA_N(MLDSA_N)
    ) sk_pack_i (
        .clk, .reset_n, .start, .zeroize, .dest_addr,
        .str_valid, .str_data, .err_pulse,
        .key_wr_en, .key_wr_addr, .key_wr_data, .run_done
    );

    key_mem #(
        .MLDSA_K(MLDSA_K), .MLDSA_L(MLDSA_L), .MLDSA_N(MLDSA_N)
    ) key_mem_i (
        .clk,
        .wr_en   (key_wr_en),
        .wr_addr (key_wr_addr),
        .wr_data (key_wr_data),
        .rd_addr (key_rd_addr),
        .rd_data (key_rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/wb_host_regs.sv ====
// Wishbone classic slave with control/status registers and memory windows.
// Each window reaches 1024 entries, so the default K/L/N sizing is only
// partly visible to the host. Coefficient writes while busy are dropped.
`timescale 1ns/1ps
`default_nettype none

module wb_host_regs
    import skenc_pkg::*;
#(
    parameter int MLDSA_K = 8,
    parameter int MLDSA_L = 7,
    parameter int MLDSA_N = 256,
    localparam int ROW_AW = row_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int KEY_AW = key_aw(MLDSA_K, MLDSA_L, MLDSA_N),
    localparam int CW     = ROW_AW + $clog2(LANES)
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                wb_cyc,
    input  wire                wb_stb,
    input  wire                wb_we,
    input  wire [WB_AW-1:0]    wb_adr,
    input  wire [WB_DW-1:0]    wb_dat_w,
    input  wire [WB_DW/8-1:0]  wb_sel,
    output logic [WB_DW-1:0]   wb_dat_r,
    output logic               wb_ack,
    output logic               start,
    output logic               zeroize,
    output logic [ROW_AW-1:0]  src_row,
    output logic [KEY_AW-1:0]  dest_addr,
    input  wire                run_done,
    input  wire                err_pulse,
    output logic               irq,
    output logic               coeff_wr_en,
    output logic [CW-1:0]      coeff_wr_addr,
    output logic [COEFF_W-1:0] coeff_wr_data,
    output logic [KEY_AW-1:0]  key_rd_addr,
    input  wire [WB_DW-1:0]    key_rd_data
);

    wb_region_e       region;
    logic             req;
    logic             wr_req;
    logic             busy;
    logic             done;
    logic             error;
    logic [WB_DW-1:0] reg_rdata;

    // Byte-lane merge for the address registers.
    function automatic logic [WB_DW-1:0] merge_bytes(input logic [WB_DW-1:0] old_v,
                                                     input logic [WB_DW-1:0] new_v,
                                                     input logic [WB_DW/8-1:0] sel);
        logic [WB_DW-1:0] result;
        result = old_v;
        for (int b = 0; b < WB_DW / 8; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return result;
    endfunction

    always_comb begin
        if (wb_adr[WB_AW-1:4] == '0) begin
            region = REGION_REG;
        end else if (wb_adr[WB_AW-1:12] == COEFF_WIN[WB_AW-1:12]) begin
            region = REGION_COEFF;
        end else if (wb_adr[WB_AW-1:12] == KEY_WIN[WB_AW-1:12]) begin
            region = REGION_KEY;
        end else begin
            region = REGION_NONE;
        end
    end

    // A request is taken once, in the cycle before its acknowledge.
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;

    // Window offsets are word indices. Lane is the low three bits.
    assign coeff_wr_en   = wr_req && (region == REGION_COEFF) && (|wb_sel) && !busy;
    assign coeff_wr_addr = CW'(wb_adr[11:2]);
    assign coeff_wr_data = wb_dat_w[COEFF_W-1:0];
    assign key_rd_addr   = KEY_AW'(wb_adr[11:2]);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            zeroize   <= 1'b0;
            irq       <= 1'b0;
            src_row   <= '0;
            dest_addr <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            wb_ack  <= req;
            start   <= 1'b0;
            zeroize <= 1'b0;
            irq     <= 1'b0;
            if (wr_req && region == REGION_REG) begin
                // Zeroize wins over a start written in the same access.
                if (wb_adr == REG_CTRL && wb_sel[0]) begin
                    zeroize <= wb_dat_w[1];
                    start   <= wb_dat_w[0] && !wb_dat_w[1] && !busy;
                end
                if (wb_adr == REG_SRC_ROW) begin
                    src_row <= ROW_AW'(merge_bytes(WB_DW'(src_row), wb_dat_w, wb_sel));
                end
                if (wb_adr == REG_DEST_ADDR) begin
                    dest_addr <= KEY_AW'(merge_bytes(WB_DW'(dest_addr), wb_dat_w, wb_sel));
                end
            end

            // Late error pulses from rows still in flight are ignored once idle.
            if (zeroize) begin
                busy  <= 1'b0;
                done  <= 1'b0;
                error <= 1'b0;
            end else if (busy && (run_done || err_pulse)) begin
                busy  <= 1'b0;
                done  <= run_done && !err_pulse;
                error <= err_pulse;
                irq   <= 1'b1;
            end else if (start) begin
                busy  <= 1'b1;
                done  <= 1'b0;
                error <= 1'b0;
            end
        end
    end

    always_comb begin
        case (wb_adr)
            REG_STATUS:    reg_rdata = WB_DW'({error, done, busy});
            REG_SRC_ROW:   reg_rdata = WB_DW'(src_row);
            REG_DEST_ADDR: reg_rdata = WB_DW'(dest_addr);
            default:       reg_rdata = '0;
        endcase
        case (region)
            REGION_REG: wb_dat_r = reg_rdata;
            REGION_KEY: wb_dat_r = key_rd_data;
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/skenc_pkg.sv
logic/wb_host_regs.sv
logic/coeff_mem.sv
logic/sk_fetch.sv
logic/sk_coeff_map.sv
logic/sk_pack.sv
logic/key_mem.sv
logic/skenc_top.sv
bench/skenc_tb.sv
